/* ctrlPkg.sv */
package ctrlPkg;

	typedef logic [31:0] instrT;

	// Instruction field positions
	localparam int OPC_MSB = 6;
	localparam int OPC_LSB = 0;
	localparam int F3_MSB  = 14;
	localparam int F3_LSB  = 12;
	localparam int F7_MSB  = 31;
	localparam int F7_LSB  = 25;
	localparam int RS2_MSB = 24;
	localparam int RS2_LSB = 20;

	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_FRTYPE = 7'b1010011; // All FP R-type
	localparam logic [6:0] OPC_FLOAD  = 7'b0000111;
	localparam logic [6:0] OPC_FSTORE = 7'b0100111;

	localparam logic [2:0] FUNCT3_ADD  = 3'b000; // Also SUB
	localparam logic [2:0] FUNCT3_SLL  = 3'b001;
	localparam logic [2:0] FUNCT3_SLT  = 3'b010;
	localparam logic [2:0] FUNCT3_SLTU = 3'b011;
	localparam logic [2:0] FUNCT3_XOR  = 3'b100;
	localparam logic [2:0] FUNCT3_SRL  = 3'b101; // Also SRA
	localparam logic [2:0] FUNCT3_OR   = 3'b110;
	localparam logic [2:0] FUNCT3_AND  = 3'b111;

	localparam logic [2:0] FUNCT3_MUL    = 3'b000;
	localparam logic [2:0] FUNCT3_MULH   = 3'b001;
	localparam logic [2:0] FUNCT3_MULHSU = 3'b010;
	localparam logic [2:0] FUNCT3_MULHU  = 3'b011;
	localparam logic [2:0] FUNCT3_DIV    = 3'b100;
	localparam logic [2:0] FUNCT3_DIVU   = 3'b101;
	localparam logic [2:0] FUNCT3_REM    = 3'b110;
	localparam logic [2:0] FUNCT3_REMU   = 3'b111;

	localparam logic [6:0] FUNCT7_ADD    = 7'b0000000;
	localparam logic [6:0] FUNCT7_SUB    = 7'b0100000; // SUB and SRA
	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	localparam logic [6:0] FUNCT7_FADD    = 7'b0000000;
	localparam logic [6:0] FUNCT7_FSUB    = 7'b0000100;
	localparam logic [6:0] FUNCT7_FMUL    = 7'b0001000;
	localparam logic [6:0] FUNCT7_FDIV    = 7'b0001100;
	localparam logic [6:0] FUNCT7_FSQRT   = 7'b0101100;
	localparam logic [6:0] FUNCT7_FSGNJ   = 7'b0010000;
	localparam logic [6:0] FUNCT7_FMINMAX = 7'b0010100;
	localparam logic [6:0] FUNCT7_FCMP    = 7'b1010000;
	localparam logic [6:0] FUNCT7_FCVT_WS = 7'b1100000; // Float to int
	localparam logic [6:0] FUNCT7_FCVT_SW = 7'b1101000; // Int to float
	localparam logic [6:0] FUNCT7_FMV_XS  = 7'b1110000;
	localparam logic [6:0] FUNCT7_FMV_SX  = 7'b1111000;

	localparam logic [2:0] FUNCT3_FSGNJ  = 3'b000;
	localparam logic [2:0] FUNCT3_FSGNJN = 3'b001;
	localparam logic [2:0] FUNCT3_FSGNJX = 3'b010;
	localparam logic [2:0] FUNCT3_FMIN   = 3'b000;
	localparam logic [2:0] FUNCT3_FMAX   = 3'b001;
	localparam logic [2:0] FUNCT3_FLE    = 3'b000;
	localparam logic [2:0] FUNCT3_FLT    = 3'b001;
	localparam logic [2:0] FUNCT3_FEQ    = 3'b010;

	localparam logic [4:0] RS2_FCVT_W  = 5'b00000; // Signed word
	localparam logic [4:0] RS2_FCVT_WU = 5'b00001; // Unsigned word

	typedef enum logic [4:0] {
		OPNULL = 5'd0, OPADD, OPSUB, OPSLL, OPSLT, OPSLTU, OPXOR, OPSRL, OPSRA,
		OPOR, OPAND, OPLUI, OPMUL, OPMULH, OPMULHSU, OPMULHU, OPDIV, OPDIVU,
		OPREM, OPREMU
	} aluOpT;

	typedef enum logic [4:0] {
		FOPNULL = 5'd0, FOPADD, FOPSUB, FOPMUL, FOPDIV, FOPSQRT, FOPMV, FOPSGNJ,
		FOPSGNJN, FOPSGNJX, FOPMAX, FOPMIN, FOPCEQ, FOPCLE, FOPCLT, FOPCVTSW,
		FOPCVTSWU, FOPCVTWS, FOPCVTWUS
	} fpuOpT;

	typedef enum logic [1:0] {
		M2R_ALU = 2'b00,
		M2R_PC4 = 2'b01,
		M2R_MEM = 2'b10
	} mem2RegT;

	typedef enum logic [1:0] {
		PC_PLUS4  = 2'b00,
		PC_BRANCH = 2'b01,
		PC_JAL    = 2'b10,
		PC_JALR   = 2'b11
	} origPcT;

	typedef struct packed {
		logic    origAluA;     // ALU A from PC
		logic    origAluB;     // ALU B from immediate
		logic    regWrite;
		logic    memWrite;
		logic    memRead;
		mem2RegT mem2Reg;
		origPcT  origPc;
		aluOpT   aluControl;
		logic    fRegWrite;
		fpuOpT   fpAluControl;
		logic    origAFpAlu;   // FPU A from FP file
		logic    fpAlu2Reg;    // Int write from FPU result
		logic    fWriteData;   // FP write from memory
		logic    write2Mem;    // Store data from FP file
		logic    fpStart;
	} ctrlWordT;

endpackage

/* pipeStage.sv */
`timescale 1ns/10ps

module pipeStage
#(
	parameter type payloadT = logic [31:0]
)
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    inValid,
	output logic    inReady,
	input  payloadT inData,
	output logic    outValid,
	input  logic    outReady,
	output payloadT outData
);

	logic    full;
	payloadT data;

	assign inReady  = !full || outReady; // Empty or draining this cycle
	assign outValid = full;
	assign outData  = data;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			full <= 1'b0;
		else if (inValid && inReady)
			full <= 1'b1; // Refill, possibly while draining
		else if (outReady)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
			data <= inData;
	end

endmodule

/* fpuDecoder.sv */
`timescale 1ns/10ps

module fpuDecoder
(
	input  ctrlPkg::instrT    instr,
	output ctrlPkg::ctrlWordT ctrl,
	output logic              isFp
);

	logic [6:0]     opcode;
	logic [2:0]     funct3;
	logic [6:0]     funct7;
	logic [4:0]     rs2;
	ctrlPkg::fpuOpT fpOp;
	logic           toInt;  // Result goes to the integer file
	logic           intSrc; // rs1 comes from the integer file

	assign opcode = instr[ctrlPkg::OPC_MSB:ctrlPkg::OPC_LSB];
	assign funct3 = instr[ctrlPkg::F3_MSB:ctrlPkg::F3_LSB];
	assign funct7 = instr[ctrlPkg::F7_MSB:ctrlPkg::F7_LSB];
	assign rs2    = instr[ctrlPkg::RS2_MSB:ctrlPkg::RS2_LSB];

	assign isFp = (opcode == ctrlPkg::OPC_FRTYPE) || (opcode == ctrlPkg::OPC_FLOAD) ||
		(opcode == ctrlPkg::OPC_FSTORE);

	always_comb
	begin
		ctrl   = '0;
		fpOp   = ctrlPkg::FOPNULL;
		toInt  = 1'b0;
		intSrc = 1'b0;
		case (opcode)
			ctrlPkg::OPC_FRTYPE:
			begin
				case (funct7)
					ctrlPkg::FUNCT7_FADD:  fpOp = ctrlPkg::FOPADD;
					ctrlPkg::FUNCT7_FSUB:  fpOp = ctrlPkg::FOPSUB;
					ctrlPkg::FUNCT7_FMUL:  fpOp = ctrlPkg::FOPMUL;
					ctrlPkg::FUNCT7_FDIV:  fpOp = ctrlPkg::FOPDIV;
					ctrlPkg::FUNCT7_FSQRT: fpOp = ctrlPkg::FOPSQRT; // rs2 ignored
					ctrlPkg::FUNCT7_FMV_SX:
					begin
						fpOp   = ctrlPkg::FOPMV;
						intSrc = 1'b1;
					end
					ctrlPkg::FUNCT7_FMV_XS:
					begin
						fpOp  = ctrlPkg::FOPMV;
						toInt = 1'b1;
					end
					ctrlPkg::FUNCT7_FSGNJ:
						case (funct3)
							ctrlPkg::FUNCT3_FSGNJ:  fpOp = ctrlPkg::FOPSGNJ;
							ctrlPkg::FUNCT3_FSGNJN: fpOp = ctrlPkg::FOPSGNJN;
							ctrlPkg::FUNCT3_FSGNJX: fpOp = ctrlPkg::FOPSGNJX;
							default:                fpOp = ctrlPkg::FOPNULL;
						endcase
					ctrlPkg::FUNCT7_FMINMAX:
						case (funct3)
							ctrlPkg::FUNCT3_FMIN: fpOp = ctrlPkg::FOPMIN;
							ctrlPkg::FUNCT3_FMAX: fpOp = ctrlPkg::FOPMAX;
							default:              fpOp = ctrlPkg::FOPNULL;
						endcase
					ctrlPkg::FUNCT7_FCMP:
					begin
						toInt = 1'b1;
						case (funct3)
							ctrlPkg::FUNCT3_FEQ: fpOp = ctrlPkg::FOPCEQ;
							ctrlPkg::FUNCT3_FLE: fpOp = ctrlPkg::FOPCLE;
							ctrlPkg::FUNCT3_FLT: fpOp = ctrlPkg::FOPCLT;
							default:             fpOp = ctrlPkg::FOPNULL;
						endcase
					end
					ctrlPkg::FUNCT7_FCVT_SW:
					begin
						intSrc = 1'b1;
						if (rs2 == ctrlPkg::RS2_FCVT_W)
							fpOp = ctrlPkg::FOPCVTSW;
						else if (rs2 == ctrlPkg::RS2_FCVT_WU)
							fpOp = ctrlPkg::FOPCVTSWU;
					end
					ctrlPkg::FUNCT7_FCVT_WS:
					begin
						toInt = 1'b1;
						if (rs2 == ctrlPkg::RS2_FCVT_W)
							fpOp = ctrlPkg::FOPCVTWS;
						else if (rs2 == ctrlPkg::RS2_FCVT_WU)
							fpOp = ctrlPkg::FOPCVTWUS;
					end
					default: fpOp = ctrlPkg::FOPNULL;
				endcase
				// Unmatched sub-encodings leave the word all zero
				if (fpOp != ctrlPkg::FOPNULL)
				begin
					ctrl.regWrite     = toInt;
					ctrl.fpAlu2Reg    = toInt;
					ctrl.fRegWrite    = !toInt;
					ctrl.origAFpAlu   = !intSrc;
					ctrl.fpAluControl = fpOp;
					ctrl.fpStart      = 1'b1;
				end
			end
			ctrlPkg::OPC_FLOAD:
			begin
				ctrl.origAluB   = 1'b1;
				ctrl.memRead    = 1'b1;
				ctrl.mem2Reg    = ctrlPkg::M2R_MEM;
				ctrl.aluControl = ctrlPkg::OPADD; // Address calc
				ctrl.fRegWrite  = 1'b1;
				ctrl.fWriteData = 1'b1;
			end
			ctrlPkg::OPC_FSTORE:
			begin
				ctrl.origAluB   = 1'b1;
				ctrl.memWrite   = 1'b1;
				ctrl.aluControl = ctrlPkg::OPADD;
				ctrl.write2Mem  = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

/* controlDecoder.sv */
`timescale 1ns/10ps

module controlDecoder
(
	input  ctrlPkg::instrT    instr,
	output ctrlPkg::ctrlWordT ctrl
);

	logic [6:0]        opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	ctrlPkg::aluOpT    baseOp; // Shared OP-IMM / R-type op
	ctrlPkg::aluOpT    mulOp;
	ctrlPkg::ctrlWordT intCtrl;
	ctrlPkg::ctrlWordT fpCtrl;
	logic              isFp;

	assign opcode = instr[ctrlPkg::OPC_MSB:ctrlPkg::OPC_LSB];
	assign funct3 = instr[ctrlPkg::F3_MSB:ctrlPkg::F3_LSB];
	assign funct7 = instr[ctrlPkg::F7_MSB:ctrlPkg::F7_LSB];

	fpuDecoder i_fpuDecoder
	(
		.instr (instr),
		.ctrl  (fpCtrl),
		.isFp  (isFp)
	);

	always_comb
	begin
		baseOp = ctrlPkg::OPNULL;
		case (funct3)
			ctrlPkg::FUNCT3_ADD:  baseOp = ctrlPkg::OPADD;
			ctrlPkg::FUNCT3_SLL:  baseOp = ctrlPkg::OPSLL;
			ctrlPkg::FUNCT3_SLT:  baseOp = ctrlPkg::OPSLT;
			ctrlPkg::FUNCT3_SLTU: baseOp = ctrlPkg::OPSLTU;
			ctrlPkg::FUNCT3_XOR:  baseOp = ctrlPkg::OPXOR;
			ctrlPkg::FUNCT3_SRL:
				baseOp = (funct7 == ctrlPkg::FUNCT7_SUB) ? ctrlPkg::OPSRA : ctrlPkg::OPSRL;
			ctrlPkg::FUNCT3_OR:   baseOp = ctrlPkg::OPOR;
			ctrlPkg::FUNCT3_AND:  baseOp = ctrlPkg::OPAND;
			default:              baseOp = ctrlPkg::OPNULL;
		endcase
	end

	always_comb
	begin
		mulOp = ctrlPkg::OPNULL;
		case (funct3)
			ctrlPkg::FUNCT3_MUL:    mulOp = ctrlPkg::OPMUL;
			ctrlPkg::FUNCT3_MULH:   mulOp = ctrlPkg::OPMULH;
			ctrlPkg::FUNCT3_MULHSU: mulOp = ctrlPkg::OPMULHSU;
			ctrlPkg::FUNCT3_MULHU:  mulOp = ctrlPkg::OPMULHU;
			ctrlPkg::FUNCT3_DIV:    mulOp = ctrlPkg::OPDIV;
			ctrlPkg::FUNCT3_DIVU:   mulOp = ctrlPkg::OPDIVU;
			ctrlPkg::FUNCT3_REM:    mulOp = ctrlPkg::OPREM;
			ctrlPkg::FUNCT3_REMU:   mulOp = ctrlPkg::OPREMU;
			default:                mulOp = ctrlPkg::OPNULL;
		endcase
	end

	// Every legal integer op has a non-null ALU code
	always_comb
	begin
		intCtrl = '0;
		case (opcode)
			ctrlPkg::OPC_LOAD:
			begin
				intCtrl.origAluB   = 1'b1;
				intCtrl.regWrite   = 1'b1;
				intCtrl.memRead    = 1'b1;
				intCtrl.mem2Reg    = ctrlPkg::M2R_MEM;
				intCtrl.aluControl = ctrlPkg::OPADD;
			end
			ctrlPkg::OPC_OPIMM:
			begin
				intCtrl.origAluB   = 1'b1;
				intCtrl.regWrite   = 1'b1;
				intCtrl.aluControl = baseOp;
			end
			ctrlPkg::OPC_AUIPC:
			begin
				intCtrl.origAluA   = 1'b1;
				intCtrl.origAluB   = 1'b1;
				intCtrl.regWrite   = 1'b1;
				intCtrl.aluControl = ctrlPkg::OPADD;
			end
			ctrlPkg::OPC_STORE:
			begin
				intCtrl.origAluB   = 1'b1;
				intCtrl.memWrite   = 1'b1;
				intCtrl.aluControl = ctrlPkg::OPADD;
			end
			ctrlPkg::OPC_RTYPE:
			begin
				intCtrl.regWrite = 1'b1;
				if (funct7 == ctrlPkg::FUNCT7_ADD)
					intCtrl.aluControl = baseOp;
				else if (funct7 == ctrlPkg::FUNCT7_SUB)
					intCtrl.aluControl = (funct3 == ctrlPkg::FUNCT3_ADD) ? ctrlPkg::OPSUB : baseOp;
				else if (funct7 == ctrlPkg::FUNCT7_MULDIV)
					intCtrl.aluControl = mulOp;
			end
			ctrlPkg::OPC_LUI:
			begin
				intCtrl.origAluB   = 1'b1;
				intCtrl.regWrite   = 1'b1;
				intCtrl.aluControl = ctrlPkg::OPLUI;
			end
			ctrlPkg::OPC_BRANCH:
			begin
				intCtrl.origPc     = ctrlPkg::PC_BRANCH;
				intCtrl.aluControl = ctrlPkg::OPADD;
			end
			ctrlPkg::OPC_JALR:
			begin
				intCtrl.regWrite   = 1'b1;
				intCtrl.mem2Reg    = ctrlPkg::M2R_PC4; // Link address
				intCtrl.origPc     = ctrlPkg::PC_JALR;
				intCtrl.aluControl = ctrlPkg::OPADD;
			end
			ctrlPkg::OPC_JAL:
			begin
				intCtrl.regWrite   = 1'b1;
				intCtrl.mem2Reg    = ctrlPkg::M2R_PC4;
				intCtrl.origPc     = ctrlPkg::PC_JAL;
				intCtrl.aluControl = ctrlPkg::OPADD;
			end
			default: intCtrl = '0;
		endcase
		if (intCtrl.aluControl == ctrlPkg::OPNULL)
			intCtrl = '0; // Bad funct7 in R-type
	end

	assign ctrl = isFp ? fpCtrl : intCtrl;

endmodule

/* ctrlDecodeTop.sv */
`timescale 1ns/10ps

module ctrlDecodeTop
(
	input  logic              clk,
	input  logic              rstN,
	input  logic              instrValid,
	output logic              instrReady,
	input  ctrlPkg::instrT    instr,
	output logic              ctrlValid,
	input  logic              ctrlReady,
	output ctrlPkg::ctrlWordT ctrl
);

	logic              midValid;  // Input stage to output stage
	logic              midReady;
	ctrlPkg::instrT    heldInstr;
	ctrlPkg::ctrlWordT decoded;

	pipeStage #(.payloadT(ctrlPkg::instrT)) i_inStage
	(
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (instrValid),
		.inReady  (instrReady),
		.inData   (instr),
		.outValid (midValid),
		.outReady (midReady),
		.outData  (heldInstr)
	);

	controlDecoder i_controlDecoder
	(
		.instr (heldInstr),
		.ctrl  (decoded)
	);

	pipeStage #(.payloadT(ctrlPkg::ctrlWordT)) i_outStage
	(
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (midValid),
		.inReady  (midReady),
		.inData   (decoded),
		.outValid (ctrlValid),
		.outReady (ctrlReady),
		.outData  (ctrl)
	);

endmodule

/* ctrlDecodeTop_checker.sv */
`timescale 1ns/10ps

module ctrlDecodeTop_checker
(
	input logic              clk,
	input logic              rstN,
	input logic              instrReady,
	input logic              ctrlValid,
	input logic              ctrlReady,
	input ctrlPkg::ctrlWordT ctrl
);

	int failCount = 0; // Collected by the testbench top

	// Output word held until it is taken
	ctrlHeld: assert property (@(posedge clk) disable iff (!rstN)
		ctrlValid && !ctrlReady |=> ctrlValid && $stable(ctrl))
	else
	begin
		failCount++;
		$error("ctrlValid dropped or ctrl changed before a transfer");
	end

	readyAfterReset: assert property (@(posedge clk) !rstN |=> instrReady)
	else
	begin
		failCount++;
		$error("instrReady low after a reset edge");
	end

	idleInReset: assert property (@(posedge clk) !rstN |=> !ctrlValid)
	else
	begin
		failCount++;
		$error("ctrlValid high during reset");
	end

endmodule

/* tbScoreboard.sv */
`timescale 1ns/10ps

module tbScoreboard
(
	input  logic              clk,
	input  logic              rstN,
	input  logic              instrValid,
	input  logic              instrReady,
	input  ctrlPkg::instrT    instr,
	input  logic              ctrlValid,
	input  logic              ctrlReady,
	input  ctrlPkg::ctrlWordT ctrl,
	output int                valueErrors,
	output int                timingErrors,
	output int                outCount,
	output int                pendingCount
);

	ctrlPkg::ctrlWordT expQ[$];
	int                acceptQ[$]; // Edge of each input transfer
	int                cycle = 0;
	int                lastStall = 0; // Last edge with ctrlReady low
	int                nValue = 0;
	int                nTiming = 0;
	int                nOut = 0;
	ctrlPkg::ctrlWordT expWord;
	int                acceptCycle;

	function automatic ctrlPkg::aluOpT baseOp(input logic [2:0] f3, input logic alt);
		case (f3)
			3'd0:    return ctrlPkg::OPADD;
			3'd1:    return ctrlPkg::OPSLL;
			3'd2:    return ctrlPkg::OPSLT;
			3'd3:    return ctrlPkg::OPSLTU;
			3'd4:    return ctrlPkg::OPXOR;
			3'd5:    return alt ? ctrlPkg::OPSRA : ctrlPkg::OPSRL;
			3'd6:    return ctrlPkg::OPOR;
			default: return ctrlPkg::OPAND;
		endcase
	endfunction

	// Flags are origAluA, origAluB, regWrite, memWrite, memRead
	function automatic ctrlPkg::ctrlWordT intWord(input logic [4:0] flags,
		input ctrlPkg::mem2RegT m2r, input ctrlPkg::origPcT pc, input ctrlPkg::aluOpT op);
		ctrlPkg::ctrlWordT w;
		w = '0;
		if (op != ctrlPkg::OPNULL)
		begin
			{w.origAluA, w.origAluB, w.regWrite, w.memWrite, w.memRead} = flags;
			w.mem2Reg    = m2r;
			w.origPc     = pc;
			w.aluControl = op;
		end
		return w;
	endfunction

	function automatic ctrlPkg::ctrlWordT fpWord(input ctrlPkg::fpuOpT op, input logic toInt,
		input logic fromInt);
		ctrlPkg::ctrlWordT w;
		w = '0;
		if (op != ctrlPkg::FOPNULL)
		begin
			w.fpAluControl = op;
			w.regWrite     = toInt;
			w.fpAlu2Reg    = toInt;
			w.fRegWrite    = !toInt;
			w.origAFpAlu   = !fromInt;
			w.fpStart      = 1'b1;
		end
		return w;
	endfunction

	function automatic ctrlPkg::ctrlWordT expectedCtrl(input ctrlPkg::instrT w);
		ctrlPkg::ctrlWordT c;
		logic [6:0]        f7;
		logic [2:0]        f3;
		ctrlPkg::aluOpT    op;
		ctrlPkg::fpuOpT    fop;
		f7  = w[31:25];
		f3  = w[14:12];
		op  = ctrlPkg::OPNULL;
		fop = ctrlPkg::FOPNULL;
		c   = '0;
		case (w[6:0])
			ctrlPkg::OPC_LOAD:
				c = intWord(5'b01101, ctrlPkg::M2R_MEM, ctrlPkg::PC_PLUS4, ctrlPkg::OPADD);
			ctrlPkg::OPC_OPIMM:
				c = intWord(5'b01100, ctrlPkg::M2R_ALU, ctrlPkg::PC_PLUS4,
					baseOp(f3, f7 == ctrlPkg::FUNCT7_SUB));
			ctrlPkg::OPC_AUIPC:
				c = intWord(5'b11100, ctrlPkg::M2R_ALU, ctrlPkg::PC_PLUS4, ctrlPkg::OPADD);
			ctrlPkg::OPC_STORE:
				c = intWord(5'b01010, ctrlPkg::M2R_ALU, ctrlPkg::PC_PLUS4, ctrlPkg::OPADD);
			ctrlPkg::OPC_RTYPE:
			begin
				if (f7 == ctrlPkg::FUNCT7_MULDIV)
					op = ctrlPkg::aluOpT'(ctrlPkg::OPMUL + 5'(f3)); // M ops in funct3 order
				else if (f7 == ctrlPkg::FUNCT7_SUB && f3 == 3'd0)
					op = ctrlPkg::OPSUB;
				else if (f7 == ctrlPkg::FUNCT7_SUB || f7 == ctrlPkg::FUNCT7_ADD)
					op = baseOp(f3, f7 == ctrlPkg::FUNCT7_SUB);
				c = intWord(5'b00100, ctrlPkg::M2R_ALU, ctrlPkg::PC_PLUS4, op);
			end
			ctrlPkg::OPC_LUI:
				c = intWord(5'b01100, ctrlPkg::M2R_ALU, ctrlPkg::PC_PLUS4, ctrlPkg::OPLUI);
			ctrlPkg::OPC_BRANCH:
				c = intWord(5'b00000, ctrlPkg::M2R_ALU, ctrlPkg::PC_BRANCH, ctrlPkg::OPADD);
			ctrlPkg::OPC_JALR:
				c = intWord(5'b00100, ctrlPkg::M2R_PC4, ctrlPkg::PC_JALR, ctrlPkg::OPADD);
			ctrlPkg::OPC_JAL:
				c = intWord(5'b00100, ctrlPkg::M2R_PC4, ctrlPkg::PC_JAL, ctrlPkg::OPADD);
			ctrlPkg::OPC_FLOAD:
			begin
				c = intWord(5'b01001, ctrlPkg::M2R_MEM, ctrlPkg::PC_PLUS4, ctrlPkg::OPADD);
				c.fRegWrite  = 1'b1;
				c.fWriteData = 1'b1;
			end
			ctrlPkg::OPC_FSTORE:
			begin
				c = intWord(5'b01010, ctrlPkg::M2R_ALU, ctrlPkg::PC_PLUS4, ctrlPkg::OPADD);
				c.write2Mem = 1'b1;
			end
			ctrlPkg::OPC_FRTYPE:
			begin
				casez ({f7, f3, w[24:20]}) // Key is funct7, funct3, rs2
					{ctrlPkg::FUNCT7_FADD, 3'b???, 5'b?????}:  fop = ctrlPkg::FOPADD;
					{ctrlPkg::FUNCT7_FSUB, 3'b???, 5'b?????}:  fop = ctrlPkg::FOPSUB;
					{ctrlPkg::FUNCT7_FMUL, 3'b???, 5'b?????}:  fop = ctrlPkg::FOPMUL;
					{ctrlPkg::FUNCT7_FDIV, 3'b???, 5'b?????}:  fop = ctrlPkg::FOPDIV;
					{ctrlPkg::FUNCT7_FSQRT, 3'b???, 5'b?????}: fop = ctrlPkg::FOPSQRT;
					{ctrlPkg::FUNCT7_FMV_SX, 3'b???, 5'b?????}: fop = ctrlPkg::FOPMV;
					{ctrlPkg::FUNCT7_FMV_XS, 3'b???, 5'b?????}: fop = ctrlPkg::FOPMV;
					{ctrlPkg::FUNCT7_FSGNJ, 3'd0, 5'b?????}:   fop = ctrlPkg::FOPSGNJ;
					{ctrlPkg::FUNCT7_FSGNJ, 3'd1, 5'b?????}:   fop = ctrlPkg::FOPSGNJN;
					{ctrlPkg::FUNCT7_FSGNJ, 3'd2, 5'b?????}:   fop = ctrlPkg::FOPSGNJX;
					{ctrlPkg::FUNCT7_FMINMAX, 3'd0, 5'b?????}: fop = ctrlPkg::FOPMIN;
					{ctrlPkg::FUNCT7_FMINMAX, 3'd1, 5'b?????}: fop = ctrlPkg::FOPMAX;
					{ctrlPkg::FUNCT7_FCMP, 3'd0, 5'b?????}:    fop = ctrlPkg::FOPCLE;
					{ctrlPkg::FUNCT7_FCMP, 3'd1, 5'b?????}:    fop = ctrlPkg::FOPCLT;
					{ctrlPkg::FUNCT7_FCMP, 3'd2, 5'b?????}:    fop = ctrlPkg::FOPCEQ;
					{ctrlPkg::FUNCT7_FCVT_SW, 3'b???, 5'd0}:   fop = ctrlPkg::FOPCVTSW;
					{ctrlPkg::FUNCT7_FCVT_SW, 3'b???, 5'd1}:   fop = ctrlPkg::FOPCVTSWU;
					{ctrlPkg::FUNCT7_FCVT_WS, 3'b???, 5'd0}:   fop = ctrlPkg::FOPCVTWS;
					{ctrlPkg::FUNCT7_FCVT_WS, 3'b???, 5'd1}:   fop = ctrlPkg::FOPCVTWUS;
					default:                                   fop = ctrlPkg::FOPNULL;
				endcase
				c = fpWord(fop,
					f7 == ctrlPkg::FUNCT7_FMV_XS || f7 == ctrlPkg::FUNCT7_FCMP ||
					f7 == ctrlPkg::FUNCT7_FCVT_WS,
					f7 == ctrlPkg::FUNCT7_FMV_SX || f7 == ctrlPkg::FUNCT7_FCVT_SW);
			end
			default: c = '0;
		endcase
		return c;
	endfunction

	always @(posedge clk)
	begin
		cycle = cycle + 1;
		if (!ctrlReady)
			lastStall = cycle;
		if (rstN)
		begin
			// Pop first since an output word is always older than a new input
			if (ctrlValid && ctrlReady)
			begin
				if (expQ.size() == 0)
				begin
					nValue = nValue + 1;
					$display("Output at %0t ns arrived with no input word waiting for it", $time);
				end
				else
				begin
					expWord     = expQ.pop_front();
					acceptCycle = acceptQ.pop_front();
					nOut        = nOut + 1;
					if (ctrl !== expWord)
					begin
						nValue = nValue + 1;
						$display("ERROR %0t ns: word %0d ctrl %h, expected %h", $time, nOut, ctrl,
							expWord);
					end
					if (lastStall <= acceptCycle && cycle - acceptCycle != 2)
					begin
						nTiming = nTiming + 1;
						$display("ERROR %0t ns: word %0d latency %0d cycles, expected 2", $time, nOut,
							cycle - acceptCycle);
					end
				end
			end
			if (instrValid && instrReady)
			begin
				expQ.push_back(expectedCtrl(instr));
				acceptQ.push_back(cycle);
			end
		end
		valueErrors  <= nValue;
		timingErrors <= nTiming;
		outCount     <= nOut;
		pendingCount <= expQ.size();
	end

endmodule

/* tbCtrlDecode.sv */
`timescale 1ns/10ps

module tbCtrlDecode;

	localparam int NUM_WORDS   = 400;
	localparam int FINAL_WORDS = 100; // Sent with ctrlReady held high
	localparam int CYCLE_LIMIT = NUM_WORDS * 10 + 100;

	logic              clk;
	logic              rstN;
	logic              instrValid;
	logic              instrReady;
	ctrlPkg::instrT    instr;
	logic              ctrlValid;
	logic              ctrlReady;
	ctrlPkg::ctrlWordT ctrl;
	int                seed;
	int                issued;
	int                cycles = 0;
	logic              taken = 1'b0; // Input transfer at the last edge
	int                valueErrors;
	int                timingErrors;
	int                outCount;
	int                pendingCount;
	int                assertFails;

	// Opcodes with many sub-encodings are listed several times
	logic [6:0] legalOps [32] = '{ctrlPkg::OPC_LOAD, ctrlPkg::OPC_AUIPC, ctrlPkg::OPC_STORE,
		ctrlPkg::OPC_LUI, ctrlPkg::OPC_BRANCH, ctrlPkg::OPC_JALR, ctrlPkg::OPC_JAL,
		ctrlPkg::OPC_FLOAD, ctrlPkg::OPC_FSTORE,
		ctrlPkg::OPC_OPIMM, ctrlPkg::OPC_OPIMM, ctrlPkg::OPC_OPIMM, ctrlPkg::OPC_OPIMM,
		ctrlPkg::OPC_OPIMM,
		ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE,
		ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE,
		ctrlPkg::OPC_RTYPE, ctrlPkg::OPC_RTYPE,
		ctrlPkg::OPC_FRTYPE, ctrlPkg::OPC_FRTYPE, ctrlPkg::OPC_FRTYPE, ctrlPkg::OPC_FRTYPE,
		ctrlPkg::OPC_FRTYPE, ctrlPkg::OPC_FRTYPE, ctrlPkg::OPC_FRTYPE, ctrlPkg::OPC_FRTYPE};
	logic [6:0] fpF7 [12] = '{ctrlPkg::FUNCT7_FADD, ctrlPkg::FUNCT7_FSUB, ctrlPkg::FUNCT7_FMUL,
		ctrlPkg::FUNCT7_FDIV, ctrlPkg::FUNCT7_FSQRT, ctrlPkg::FUNCT7_FSGNJ,
		ctrlPkg::FUNCT7_FMINMAX, ctrlPkg::FUNCT7_FCMP, ctrlPkg::FUNCT7_FCVT_WS,
		ctrlPkg::FUNCT7_FCVT_SW, ctrlPkg::FUNCT7_FMV_XS, ctrlPkg::FUNCT7_FMV_SX};
	logic [6:0] intF7 [3] = '{ctrlPkg::FUNCT7_ADD, ctrlPkg::FUNCT7_SUB, ctrlPkg::FUNCT7_MULDIV};

	always #10 clk = ~clk;

	ctrlDecodeTop i_ctrlDecodeTop
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.instr      (instr),
		.ctrlValid  (ctrlValid),
		.ctrlReady  (ctrlReady),
		.ctrl       (ctrl)
	);

	tbScoreboard i_tbScoreboard
	(
		.clk          (clk),
		.rstN         (rstN),
		.instrValid   (instrValid),
		.instrReady   (instrReady),
		.instr        (instr),
		.ctrlValid    (ctrlValid),
		.ctrlReady    (ctrlReady),
		.ctrl         (ctrl),
		.valueErrors  (valueErrors),
		.timingErrors (timingErrors),
		.outCount     (outCount),
		.pendingCount (pendingCount)
	);

	bind ctrlDecodeTop ctrlDecodeTop_checker i_handshakeChecker
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrReady (instrReady),
		.ctrlValid  (ctrlValid),
		.ctrlReady  (ctrlReady),
		.ctrl       (ctrl)
	);

	function automatic ctrlPkg::instrT randomWord();
		ctrlPkg::instrT w;
		logic [6:0]     opc;
		w = $random(seed);
		if ($unsigned($random(seed)) % 10 < 8) // Legal opcode, fields mostly legal
		begin
			opc    = legalOps[5'($random(seed))];
			w[6:0] = opc;
			if ($unsigned($random(seed)) % 5 != 0)
			begin
				if (opc == ctrlPkg::OPC_FRTYPE)
					w[31:25] = fpF7[4'($unsigned($random(seed)) % 12)];
				else
					w[31:25] = intF7[2'($unsigned($random(seed)) % 3)];
			end
			if ($unsigned($random(seed)) % 5 != 0)
			begin
				if (opc == ctrlPkg::OPC_FRTYPE)
					w[14:12] = 3'($unsigned($random(seed)) % 3);
				w[24:20] = 5'($unsigned($random(seed)) % 2); // Convert selectors
			end
		end
		return w;
	endfunction

	always @(posedge clk)
	begin
		taken  <= rstN && instrValid && instrReady;
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT)
		begin
			$display("Run stalled: %0d of %0d words came out within %0d cycles", outCount,
				NUM_WORDS, cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	initial
	begin
		seed       = 32'h6d43;
		clk        = 1'b0;
		rstN       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		ctrlReady  = 1'b0;
		issued     = 0;
		repeat (8) @(negedge clk);
		rstN = 1'b1;
		while (outCount < NUM_WORDS)
		begin
			@(negedge clk);
			if (issued >= NUM_WORDS - FINAL_WORDS)
				ctrlReady = 1'b1;
			else
				ctrlReady = $random(seed) & 1;
			if (!instrValid || taken)
			begin
				if (issued < NUM_WORDS && (issued >= NUM_WORDS - FINAL_WORDS ||
					$unsigned($random(seed)) % 4 != 0))
				begin
					instr      = randomWord();
					instrValid = 1'b1;
					issued     = issued + 1;
				end
				else
					instrValid = 1'b0;
			end
		end
		repeat (5) @(negedge clk); // Catch duplicated outputs
		assertFails = i_ctrlDecodeTop.i_handshakeChecker.failCount;
		if (pendingCount != 0)
			$display("Scoreboard still holds %0d expected words that never came out", pendingCount);
		$display("Errors: %0d value, %0d latency, %0d assertion, %0d missing", valueErrors,
			timingErrors, assertFails, pendingCount);
		if (valueErrors + timingErrors + assertFails + pendingCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* verilog.f */
ctrlPkg.sv
pipeStage.sv
fpuDecoder.sv
controlDecoder.sv
ctrlDecodeTop.sv
ctrlDecodeTop_checker.sv
tbScoreboard.sv
tbCtrlDecode.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCtrlDecode
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
